// ==== Bender.yml ====
package:
  name: tetris_core

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/tetris_pkg.sv
      - rtl/piece_shape.sv
      - rtl/collision_check.sv
      - rtl/playfield.sv
      - rtl/tetris_fsm.sv
      - rtl/wb_grid_port.sv
      - rtl/tetris_top.sv
  - target: test
    include_dirs:
      - rtl
      - bench
    files:
      - bench/tb_tetris.sv

// ==== bench/tb_shapes.svh ====
`ifndef TB_SHAPES_SVH
`define TB_SHAPES_SVH

//////////////////////////////
// reference shapes and grid model
//////////////////////////////
localparam int MV_RIGHT = 0;
localparam int MV_LEFT  = 1;
localparam int MV_RR    = 2;
localparam int MV_RL    = 3;

int unsigned model [0:20][0:9]; // expected colour per cell
int cur_kind, cur_rot, cur_row, cur_col; // piece the DUT is holding
int exp_spawned;
int exp_lines;
bit exp_over;

// 4x4 occupancy, bit = box_row*4 + box_col
function automatic logic [15:0] shape_mask(input int kind, input int rot);
  logic [63:0] turns; // rot 3 in the top word
  case (kind)
    0: turns = {16'h2222, 16'h0f00, 16'h4444, 16'h00f0}; // I
    1: turns = {4{16'h0066}};                            // O
    2: turns = {16'h0232, 16'h0270, 16'h0262, 16'h0072}; // T
    3: turns = {16'h0231, 16'h0360, 16'h0462, 16'h0036}; // S
    4: turns = {16'h0132, 16'h0630, 16'h0264, 16'h0063}; // Z
    5: turns = {16'h0322, 16'h0470, 16'h0226, 16'h0071}; // J
    6: turns = {16'h0223, 16'h0170, 16'h0622, 16'h0074}; // L
    default: turns = '0;
  endcase
  return turns[16 * rot +: 16];
endfunction

function automatic bit piece_fits(input int kind, input int rot, input int row, input int col);
  logic [15:0] m;
  int r;
  int c;
  m = shape_mask(kind, rot & 3);
  for (int b = 0; b < 16; b++) begin
    if (m[b]) begin
      r = row + b / 4;
      c = col + b % 4;
      if (c < 0 || c > 9 || r > 20) return 1'b0; // walls, floor
      if (model[r][c] != 0) return 1'b0;
    end
  end
  return 1'b1;
endfunction

// 30-bit row word, col 0 lowest
function automatic logic [31:0] row_word(input int r);
  logic [31:0] w;
  w = '0;
  for (int c = 0; c < 10; c++) w |= model[r][c] << (3 * c);
  return w;
endfunction

task automatic model_reset();
  for (int r = 0; r < 21; r++)
    for (int c = 0; c < 10; c++) model[r][c] = 0;
  exp_spawned = 0;
  exp_lines   = 0;
  exp_over    = 1'b0;
endtask

// next piece in fixed cyclic order
task automatic model_spawn();
  cur_kind = exp_spawned % 7;
  cur_rot  = 0;
  cur_row  = 0;
  cur_col  = 3;
  if (piece_fits(cur_kind, cur_rot, cur_row, cur_col)) exp_spawned++;
  else exp_over = 1'b1;
endtask

task automatic apply_move(input int which);
  int nr;
  int nc;
  nr = cur_rot;
  nc = cur_col;
  case (which)
    MV_RIGHT: nc = cur_col + 1;
    MV_LEFT:  nc = cur_col - 1;
    MV_RR:    nr = (cur_rot + 1) & 3; // clockwise
    default:  nr = (cur_rot + 3) & 3;
  endcase
  if (piece_fits(cur_kind, nr, cur_row, nc)) begin
    cur_rot = nr;
    cur_col = nc;
  end
endtask

// drop, lock, clear full rows bottom up, spawn
task automatic settle_piece();
  logic [15:0] m;
  int r;
  bit full;
  while (piece_fits(cur_kind, cur_rot, cur_row + 1, cur_col)) cur_row++;
  m = shape_mask(cur_kind, cur_rot);
  for (int b = 0; b < 16; b++)
    if (m[b]) model[cur_row + b / 4][cur_col + b % 4] = cur_kind + 1;
  r = 20;
  while (r >= 0) begin
    full = 1'b1;
    for (int c = 0; c < 10; c++) if (model[r][c] == 0) full = 1'b0;
    if (full) begin
      for (int k = r; k > 0; k--)
        for (int c = 0; c < 10; c++) model[k][c] = model[k-1][c];
      for (int c = 0; c < 10; c++) model[0][c] = 0;
      exp_lines++; // same row again
    end else begin
      r--;
    end
  end
  model_spawn();
endtask

`endif

// ==== bench/tb_tetris.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tetris_settings.svh"

module tb_tetris;

  localparam int MAX_CYCLES = 40000; // ~60 pieces x 25 ticks + bus reads, with margin
  localparam int ST_FALL    = 3;
  localparam int STATUS_ADR = 21;

  logic clk, rst, en, right, left, rr, rl, tick;
  logic cyc, stb, we;
  logic [`WB_ADDR_W-1:0] adr;
  logic [`WB_DATA_W-1:0] dat_w, dat_r;
  logic ack, game_over;

  int errors;
  int checks;
  int cycles;
  int seed;
  logic [31:0] st;

  `include "tb_shapes.svh"

  tetris_top u_tetris_top (
    .clk, .rst, .en, .right, .left, .rr, .rl, .tick,
    .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack, .game_over
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk; // 100 ns
  end

  // watchdog
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////
  task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp)
      else begin
        $display("FAIL %s: expected 0x%08h, actual 0x%08h", name, exp, act);
        errors++;
      end
  endtask

  // classic read, ack must come after one cycle
  task automatic bus_read(input int a, output logic [31:0] d);
    int n;
    n = 0;
    @(negedge clk);
    cyc = 1'b1;
    stb = 1'b1;
    adr = a;
    do begin
      @(negedge clk);
      n++;
    end while (!ack);
    d   = dat_r;
    cyc = 1'b0;
    stb = 1'b0;
    expect_eq("ack_latency", 1, n);
  endtask

  task automatic hold_reset();
    rst = 1'b1;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    model_reset();
  endtask

  task automatic start_game();
    @(negedge clk);
    en = 1'b1; // IDLE -> READY -> NEW_BLOCK
    repeat (2) @(negedge clk);
    en = 1'b0;
    model_spawn();
  endtask

  task automatic press(input int which, input int times);
    repeat (times) begin
      @(negedge clk);
      case (which)
        MV_RIGHT: right = 1'b1;
        MV_LEFT:  left  = 1'b1;
        MV_RR:    rr    = 1'b1;
        default:  rl    = 1'b1;
      endcase
      @(negedge clk);
      right = 1'b0;
      left  = 1'b0;
      rr    = 1'b0;
      rl    = 1'b0;
      apply_move(which);
    end
  endtask

  // tick only while FALL, stop on new spawn or game over
  task automatic drop_piece();
    logic [31:0] s;
    int start;
    start = exp_spawned;
    bus_read(STATUS_ADR, s);
    while (s[15:8] == start[7:0] && !s[16]) begin
      if (s[19:17] == ST_FALL) begin
        @(negedge clk);
        tick = 1'b1;
        @(negedge clk);
        tick = 1'b0;
      end
      bus_read(STATUS_ADR, s);
    end
    settle_piece();
  endtask

  task automatic compare_grid(input string name);
    logic [31:0] d;
    for (int r = 0; r < 21; r++) begin
      bus_read(r, d);
      expect_eq(name, row_word(r), d);
    end
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////
  initial begin
    errors = 0;
    checks = 0;
    cycles = 0;
    seed   = 58;
    rst = 1'b1;
    en = 1'b0;
    right = 1'b0;
    left = 1'b0;
    rr = 1'b0;
    rl = 1'b0;
    tick = 1'b0;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    dat_w = '0;
    hold_reset();

    // 1: empty grid and status after reset
    compare_grid("reset_grid");
    bus_read(STATUS_ADR, st);
    expect_eq("reset_status", 32'h0, st);
    @(negedge clk);
    expect_eq("reset_game_over", 0, game_over);

    // 2: start, I piece lands flat on the floor
    start_game();
    bus_read(STATUS_ADR, st);
    expect_eq("start_state", ST_FALL, st[19:17]);
    expect_eq("start_spawned", 1, st[15:8]);
    drop_piece();
    bus_read(20, st);
    expect_eq("i_floor_row", 32'h0004_9200, st); // colour 1, cols 3..6
    compare_grid("i_drop");

    // 3: O against the left wall, extra presses ignored
    press(MV_LEFT, 6);
    drop_piece();
    bus_read(20, st);
    expect_eq("o_left_col0", 2, st[2:0]);
    compare_grid("o_left");

    // 4: T rotations, then right wall rotation refused
    press(MV_RR, 1);
    press(MV_RL, 1);
    press(MV_RL, 1);    // rot 3, narrow
    press(MV_RIGHT, 7); // into the wall
    press(MV_RR, 1);    // would cross col 9
    drop_piece();
    compare_grid("t_rotate");

    // 5: fresh game, two floor rows filled and cleared
    hold_reset();
    start_game();
    press(MV_LEFT, 3);   // I
    drop_piece();
    press(MV_RIGHT, 4);  // O
    drop_piece();
    press(MV_RIGHT, 1);  // T
    drop_piece();
    press(MV_RR, 1);     // S upright, closes the floor row
    press(MV_RIGHT, 2);
    drop_piece();
    press(MV_RR, 1);     // Z upright
    drop_piece();
    press(MV_RIGHT, 4);  // J
    drop_piece();
    press(MV_RIGHT, 4);  // L
    drop_piece();
    press(MV_LEFT, 3);   // I closes the second row
    drop_piece();
    bus_read(STATUS_ADR, st);
    expect_eq("clear_lines", exp_lines, st[7:0]);
    compare_grid("clear_shift");

    // 6: stack up until a spawn collides
    for (int i = 0; i < 40 && !exp_over; i++) drop_piece();
    bus_read(STATUS_ADR, st);
    expect_eq("over_flag", 1, st[16]);
    expect_eq("over_spawned", exp_spawned, st[15:8]);
    repeat (8) begin
      @(negedge clk);
      en    = 1'($random(seed));
      right = 1'($random(seed));
      left  = 1'($random(seed));
      rr    = 1'($random(seed));
      rl    = 1'($random(seed));
      tick  = 1'($random(seed));
    end
    @(negedge clk);
    en = 1'b0;
    right = 1'b0;
    left = 1'b0;
    rr = 1'b0;
    rl = 1'b0;
    tick = 1'b0;
    expect_eq("over_pin", 1, game_over);
    compare_grid("over_grid");
    bus_read(STATUS_ADR, st);
    expect_eq("over_spawned_frozen", exp_spawned, st[15:8]);

    $display("checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/collision_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module collision_check import tetris_pkg::*; (
  input  cells_t cells,
  input  grid_t  grid,
  output logic   blocked
);

  // any cell off the well or onto a stored block
  always_comb begin
    blocked = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (!in_field(cells[i])) begin
        blocked = 1'b1; // wall or floor
      end else if (grid[cells[i].row][cells[i].col[3:0]] != '0) begin
        blocked = 1'b1; // occupied
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/piece_shape.sv ====
`timescale 1ns/1ps
`default_nettype none

module piece_shape import tetris_pkg::*; (
  input  piece_t piece,
  output cells_t cells
);

  ////////////////////////////////
  // shape table
  ////////////////////////////////
  // entry = kind*4 + rot, one hex digit per cell
  // digit = box_row*4 + box_col, cell 0 in the low digit
  localparam logic [15:0] SHAPE_TBL [0:27] = '{
    16'h7654, 16'hea62, 16'hba98, 16'hd951, // I
    16'h6521, 16'h6521, 16'h6521, 16'h6521, // O, same every turn
    16'h6541, 16'h9651, 16'h9654, 16'h9541, // T
    16'h5421, 16'ha651, 16'h9865, 16'h9540, // S
    16'h6510, 16'h9652, 16'ha954, 16'h8541, // Z
    16'h6540, 16'h9521, 16'ha654, 16'h9851, // J
    16'h6542, 16'ha951, 16'h8654, 16'h9510  // L
  };

  logic [4:0]  idx;
  logic [15:0] ent;

  assign idx = {piece.kind, piece.rot};

  always_comb begin
    ent = 16'h0000; // kind 7 never issued
    if (idx < 5'd28) begin
      ent = SHAPE_TBL[idx];
    end
  end

  ////////////////////////////////
  // box offset -> absolute cell
  ////////////////////////////////
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      cells[i].row = piece.row + {3'b000, ent[4*i+2 +: 2]};
      cells[i].col = piece.col + $signed({3'b000, ent[4*i +: 2]}); // col may be < 0
    end
  end

endmodule

`default_nettype wire

// ==== rtl/playfield.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tetris_settings.svh"

module playfield import tetris_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       lock_en,
  input  cells_t                     lock_cells,
  input  logic [`TETRIS_COLOR_W-1:0] lock_color,
  input  logic                       clear_start,
  output grid_t                      grid,
  output logic                       clear_done,
  output logic                       lines_add
);

  localparam int ROWS = `TETRIS_ROWS;
  localparam int COLS = `TETRIS_COLS;

  logic       scanning;  // row scan in progress
  logic [4:0] scan_row;  // walks from the floor upward
  logic       row_full;
  grid_t      shifted;   // grid with scan_row removed
  logic       lock_hit;  // lock target already taken

  ////////////////////////////////
  // row scan datapath
  ////////////////////////////////
  always_comb begin
    row_full = 1'b1;
    for (int c = 0; c < COLS; c++) begin
      if (grid[scan_row][c] == '0) row_full = 1'b0;
    end
  end

  // rows at or above scan_row drop by one
  always_comb begin
    shifted = grid;
    for (int r = 1; r < ROWS; r++) begin
      if (r <= scan_row) shifted[r] = grid[r-1];
    end
    shifted[0] = '0; // fresh empty top row
  end

  always_comb begin
    lock_hit = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (!in_field(lock_cells[i])) begin
        lock_hit = 1'b1;
      end else if (grid[lock_cells[i].row][lock_cells[i].col[3:0]] != '0) begin
        lock_hit = 1'b1;
      end
    end
  end

  ////////////////////////////////
  // grid register
  ////////////////////////////////
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      grid       <= '0;
      scanning   <= 1'b0;
      scan_row   <= '0;
      clear_done <= 1'b0;
      lines_add  <= 1'b0;
    end else begin
      clear_done <= 1'b0; // both are single pulses
      lines_add  <= 1'b0;
      if (lock_en) begin
        for (int i = 0; i < 4; i++) begin
          if (in_field(lock_cells[i])) begin
            grid[lock_cells[i].row][lock_cells[i].col[3:0]] <= lock_color;
          end
        end
      end else if (scanning) begin
        if (row_full) begin
          grid      <= shifted; // same row rescanned next cycle
          lines_add <= 1'b1;
        end else if (scan_row == '0) begin
          scanning   <= 1'b0;   // passed the top
          clear_done <= 1'b1;
        end else begin
          scan_row <= scan_row - 5'd1;
        end
      end
      if (clear_start) begin
        scanning <= 1'b1;
        scan_row <= 5'(ROWS - 1); // start at the floor
      end
    end
  end

  // collision check upstream must keep locks on empty cells
  a_lock_on_empty : assert property (@(posedge clk) disable iff (rst)
    lock_en |-> !lock_hit)
    else $error("playfield: lock onto occupied or outside cell");

endmodule

`default_nettype wire

// ==== rtl/tetris_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tetris_settings.svh"

module tetris_fsm import tetris_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       en,
  input  logic                       right,
  input  logic                       left,
  input  logic                       rr,
  input  logic                       rl,
  input  logic                       tick,    // gravity pulse
  input  logic                       blocked, // for cand
  input  logic                       clear_done,
  input  logic                       lines_add,
  output piece_t                     cand,
  output piece_t                     active,
  output logic                       lock_en,
  output logic [`TETRIS_COLOR_W-1:0] lock_color,
  output logic                       clear_start,
  output state_t                     state,
  output logic [7:0]                 lines,
  output logic [7:0]                 spawned,
  output logic                       game_over
);

  state_t n_state;
  move_t  move;
  logic [2:0] sel;     // cyclic piece selector, 0..6
  piece_t spawn_p;

  ////////////////////////////////
  // candidate piece
  ////////////////////////////////
  always_comb begin
    spawn_p      = '0;
    spawn_p.kind = sel;
    spawn_p.col  = 5'sd3; // rot 0, row 0
  end

  // input priority right > left > rr > rl > tick
  always_comb begin
    move = NONE;
    if (state == FALL) begin
      if (right)     move = RIGHT;
      else if (left) move = LEFT;
      else if (rr)   move = ROT_R;
      else if (rl)   move = ROT_L;
      else if (tick) move = DOWN;
    end
  end

  always_comb begin
    cand = active;
    case (move)
      RIGHT:   cand.col = active.col + 5'sd1;
      LEFT:    cand.col = active.col - 5'sd1;
      ROT_R:   cand.rot = active.rot + 2'd1; // clockwise
      ROT_L:   cand.rot = active.rot - 2'd1;
      DOWN:    cand.row = active.row + 5'd1;
      default: cand = active;
    endcase
    if (state == NEW_BLOCK) cand = spawn_p;
  end

  ////////////////////////////////
  // next state
  ////////////////////////////////
  always_comb begin
    n_state = state;
    case (state)
      IDLE:      if (en) n_state = READY;
      READY:     if (en) n_state = NEW_BLOCK;
      NEW_BLOCK: n_state = blocked ? GAME_OVER : FALL; // spawn collides -> over
      FALL:      if (move == DOWN && blocked) n_state = LOCK;
      LOCK:      n_state = CLEAR;
      CLEAR:     if (clear_done) n_state = NEW_BLOCK;
      GAME_OVER: n_state = GAME_OVER; // only rst leaves
      default:   n_state = IDLE;
    endcase
  end

  assign lock_en    = (state == LOCK);
  assign lock_color = active.kind + 3'd1; // colour 0 is empty
  assign game_over  = (state == GAME_OVER);

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state       <= IDLE;
      active      <= '0;
      sel         <= '0;
      spawned     <= '0;
      lines       <= '0;
      clear_start <= 1'b0;
    end else begin
      state       <= n_state;
      clear_start <= (state == LOCK); // high in first CLEAR cycle
      if (lines_add) lines <= lines + 8'd1;
      if (state == NEW_BLOCK && !blocked) begin
        active  <= cand;
        spawned <= spawned + 8'd1;
        sel     <= (sel == 3'd6) ? 3'd0 : sel + 3'd1;
      end else if (move != NONE && !blocked) begin
        active <= cand; // blocked side/rot moves dropped
      end
    end
  end

  a_lock_after_fall : assert property (@(posedge clk) disable iff (rst)
    lock_en |-> $past(state) == FALL ##1 state == CLEAR)
    else $error("tetris_fsm: lock outside the fall/clear sequence");

  a_clear_on_entry : assert property (@(posedge clk) disable iff (rst)
    clear_start |-> state == CLEAR && $past(state) == LOCK)
    else $error("tetris_fsm: clear_start off CLEAR entry");

endmodule

`default_nettype wire

// ==== rtl/tetris_pkg.sv ====
`default_nettype none

`include "tetris_settings.svh"

package tetris_pkg;

  // control states
  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    READY     = 3'd1,
    NEW_BLOCK = 3'd2,
    FALL      = 3'd3,
    LOCK      = 3'd4,
    CLEAR     = 3'd5,
    GAME_OVER = 3'd6
  } state_t;

  // one move per cycle, highest priority first
  typedef enum logic [2:0] {
    RIGHT = 3'd0,
    LEFT  = 3'd1,
    ROT_R = 3'd2,
    ROT_L = 3'd3,
    DOWN  = 3'd4,
    NONE  = 3'd7
  } move_t;

  typedef struct packed {
    logic [2:0]        kind;  // I O T S Z J L
    logic [1:0]        rot;   // clockwise quarter turns
    logic [4:0]        row;   // top of 4x4 box
    logic signed [4:0] col;   // left of box, may go negative
    logic              spare;
  } piece_t;

  typedef struct packed {
    logic [4:0]        row;
    logic signed [4:0] col;
  } cell_t;

  typedef cell_t [3:0] cells_t;

  typedef logic [`TETRIS_ROWS-1:0][`TETRIS_COLS-1:0][`TETRIS_COLOR_W-1:0] grid_t;

  // true when the cell sits inside the well
  function automatic logic in_field(cell_t c);
    return !c.col[4] && (c.col[3:0] < 4'(`TETRIS_COLS)) &&
           (c.row < 5'(`TETRIS_ROWS));
  endfunction

endpackage

`default_nettype wire

// ==== rtl/tetris_settings.svh ====
`ifndef TETRIS_SETTINGS_SVH
`define TETRIS_SETTINGS_SVH

// playfield geometry
`define TETRIS_ROWS    21 // row 0 at the top, row 20 at the floor
`define TETRIS_COLS    10
`define TETRIS_COLOR_W 3  // 0 = empty, kind+1 otherwise

// wishbone sizes
`define WB_ADDR_W 5  // rows 0..20, status at 21
`define WB_DATA_W 32

`endif

// ==== rtl/tetris_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tetris_settings.svh"

module tetris_top import tetris_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  en,
  input  logic                  right,
  input  logic                  left,
  input  logic                  rr,
  input  logic                  rl,
  input  logic                  tick,
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  logic [`WB_ADDR_W-1:0] adr,
  input  logic [`WB_DATA_W-1:0] dat_w,
  output logic [`WB_DATA_W-1:0] dat_r,
  output logic                  ack,
  output logic                  game_over
);

  piece_t cand, active;
  cells_t cand_cells, active_cells;
  grid_t  grid;
  state_t state;
  logic   blocked, lock_en, clear_start, clear_done, lines_add;
  logic [`TETRIS_COLOR_W-1:0] lock_color;
  logic [7:0] lines, spawned;

  ////////////////////////////////
  // control
  ////////////////////////////////
  tetris_fsm u_fsm (
    .clk, .rst, .en, .right, .left, .rr, .rl, .tick,
    .blocked, .clear_done, .lines_add,
    .cand, .active, .lock_en, .lock_color, .clear_start,
    .state, .lines, .spawned, .game_over
  );

  ////////////////////////////////
  // datapath
  ////////////////////////////////
  piece_shape u_shape_cand   (.piece(cand),   .cells(cand_cells));   // move test
  piece_shape u_shape_active (.piece(active), .cells(active_cells)); // lock target

  collision_check u_collide (.cells(cand_cells), .grid, .blocked);

  playfield u_field (
    .clk, .rst, .lock_en, .lock_cells(active_cells), .lock_color,
    .clear_start, .grid, .clear_done, .lines_add
  );

  wb_grid_port u_wb (
    .clk, .rst, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
    .grid, .lines, .spawned, .game_over, .state
  );

endmodule

`default_nettype wire

// ==== rtl/wb_grid_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tetris_settings.svh"

module wb_grid_port import tetris_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  logic [`WB_ADDR_W-1:0] adr,
  input  logic [`WB_DATA_W-1:0] dat_w,
  output logic [`WB_DATA_W-1:0] dat_r,
  output logic                  ack,
  input  grid_t                 grid,
  input  logic [7:0]            lines,
  input  logic [7:0]            spawned,
  input  logic                  game_over,
  input  state_t                state
);

  localparam int ROWS  = `TETRIS_ROWS;
  localparam int ROW_W = `TETRIS_COLS * `TETRIS_COLOR_W; // 30 bits per row

  logic req;
  logic served; // ack given, wait for stb low
  logic [`WB_DATA_W-1:0] rd_data;

  assign req = cyc & stb;

  ////////////////////////////////
  // read mux
  ////////////////////////////////
  always_comb begin
    rd_data = '0;
    if (adr < ROWS) begin
      rd_data[ROW_W-1:0] = grid[adr]; // col 0 in bits 2:0
    end else if (adr == ROWS) begin
      rd_data[7:0]   = lines;
      rd_data[15:8]  = spawned;
      rd_data[16]    = game_over;
      rd_data[19:17] = state;
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      ack    <= 1'b0;
      served <= 1'b0;
    end else begin
      ack <= req & ~ack & ~served; // single-cycle pulse
      if (!req)     served <= 1'b0;
      else if (ack) served <= 1'b1;
    end
  end

  // writes still get an ack, data dropped
  always_ff @(posedge clk) begin
    if (req & ~ack & ~served) dat_r <= we ? '0 : rd_data;
  end

  a_ack_after_req : assert property (@(posedge clk) disable iff (rst)
    ack |-> $past(req))
    else $error("wb_grid_port: ack without a request");

  a_write_known : assert property (@(posedge clk) disable iff (rst)
    req && we |-> !$isunknown(dat_w))
    else $error("wb_grid_port: write data unknown");

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+rtl
+incdir+bench
rtl/tetris_pkg.sv
rtl/piece_shape.sv
rtl/collision_check.sv
rtl/playfield.sv
rtl/tetris_fsm.sv
rtl/wb_grid_port.sv
rtl/tetris_top.sv
bench/tb_tetris.sv
